/* source/fpu_misc_pkg.sv */
/*
 * shared widths, operation codes, latency defaults, class bit
 * positions and special result constants for the misc FPU
 */
package fpu_misc_pkg;

	// operand and field widths of the double format
	localparam int DATA_W  = 64;
	localparam int EXP_W   = 11;
	localparam int MAN_W   = 52;
	localparam int FN_W    = 3;
	localparam int COUNT_W = 7;

	typedef enum logic [1:0]
	{
		OP_SGNJ,
		OP_CLASS,
		OP_CMP,
		OP_MINMAX
	} fpu_op_e;

	////////////////////////////////////////////////
	// function codes, carried in the rounding-mode field
	////////////////////////////////////////////////
	localparam logic [FN_W-1:0] FN_SGNJ  = 3'd0;
	localparam logic [FN_W-1:0] FN_SGNJX = 3'd1;
	localparam logic [FN_W-1:0] FN_SGNJN = 3'd2;
	localparam logic [FN_W-1:0] FN_COPY  = 3'd3;

	localparam logic [FN_W-1:0] FN_FLE = 3'd0;
	localparam logic [FN_W-1:0] FN_FLT = 3'd1;
	localparam logic [FN_W-1:0] FN_FEQ = 3'd2;

	localparam logic [FN_W-1:0] FN_MIN = 3'd0;
	localparam logic [FN_W-1:0] FN_MAX = 3'd1;

	// fclass bit positions, RISC-V order
	localparam int CLS_NEG_INF  = 0;
	localparam int CLS_NEG_NORM = 1;
	localparam int CLS_NEG_SUB  = 2;
	localparam int CLS_NEG_ZERO = 3;
	localparam int CLS_POS_ZERO = 4;
	localparam int CLS_POS_SUB  = 5;
	localparam int CLS_POS_NORM = 6;
	localparam int CLS_POS_INF  = 7;
	localparam int CLS_SNAN     = 8;
	localparam int CLS_QNAN     = 9;

	localparam logic [DATA_W-1:0] CANON_NAN      = 64'h7FF8_0000_0000_0000;
	localparam logic [DATA_W-1:0] ILLEGAL_RESULT = 64'h0000_0000_DEAD_BEEF;

	// cycles from acceptance to result, each at least 2
	localparam logic [COUNT_W-1:0] DEF_SGNJ_CYCLES   = 7'd10;
	localparam logic [COUNT_W-1:0] DEF_CLASS_CYCLES  = 7'd4;
	localparam logic [COUNT_W-1:0] DEF_CMP_CYCLES    = 7'd6;
	localparam logic [COUNT_W-1:0] DEF_MINMAX_CYCLES = 7'd6;

endpackage

/* source/fpu_req_if.sv */
/*
 * captured request bundle between the sequencer and the data units
 */
interface fpu_req_if;

	// operation class and its function code
	fpu_misc_pkg::fpu_op_e          op;
	logic [fpu_misc_pkg::FN_W-1:0]  fn;

	// operands, held until the next acceptance
	logic [fpu_misc_pkg::DATA_W-1:0] opa;
	logic [fpu_misc_pkg::DATA_W-1:0] opb;

	modport seq
	(
		output op, fn, opa, opb
	);

	modport unit
	(
		input op, fn, opa, opb
	);

endinterface

/* source/fpu_op_sequencer.sv */
/*
 * request handshake FSM: accept and capture, start the latency
 * timer, present the result until it is consumed
 */
module fpu_op_sequencer
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            in_valid,
	input  fpu_misc_pkg::fpu_op_e           op,
	input  logic [fpu_misc_pkg::FN_W-1:0]   fn,
	input  logic [fpu_misc_pkg::DATA_W-1:0] opa,
	input  logic [fpu_misc_pkg::DATA_W-1:0] opb,
	output logic                            in_ready,
	fpu_req_if.seq                          req,
	output logic                            start,
	input  logic                            done,
	output logic                            capture,
	output logic                            out_valid,
	input  logic                            out_ready
);

	typedef enum logic [1:0] {IDLE, BUSY, HOLD} state_t;

	state_t state;
	logic   accept;

	assign in_ready  = (state == IDLE);
	assign accept    = in_valid && in_ready;
	assign out_valid = (state == HOLD);

	// result stage samples on the same edge that moves us to HOLD
	assign capture = (state == BUSY) && done;

	////////////////////////////////////////////////
	// state and start pulse
	////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			start <= 1'b0;
		end
		else
		begin
			start <= accept;
			case (state)
				IDLE:    if (accept) state <= BUSY;
				BUSY:    if (done) state <= HOLD;
				HOLD:    if (out_ready) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// request payload
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req.op  <= op;
			req.fn  <= fn;
			req.opa <= opa;
			req.opb <= opb;
		end
	end

endmodule

/* source/fpu_latency_timer.sv */
/*
 * down-counter that times the fixed latency of the captured operation
 */
module fpu_latency_timer
#(
	parameter logic [fpu_misc_pkg::COUNT_W-1:0] SGNJ_CYCLES   = fpu_misc_pkg::DEF_SGNJ_CYCLES,
	parameter logic [fpu_misc_pkg::COUNT_W-1:0] CLASS_CYCLES  = fpu_misc_pkg::DEF_CLASS_CYCLES,
	parameter logic [fpu_misc_pkg::COUNT_W-1:0] CMP_CYCLES    = fpu_misc_pkg::DEF_CMP_CYCLES,
	parameter logic [fpu_misc_pkg::COUNT_W-1:0] MINMAX_CYCLES = fpu_misc_pkg::DEF_MINMAX_CYCLES
)
(
	input  logic   clk,
	input  logic   rst,
	fpu_req_if.unit req,
	input  logic   start,
	output logic   done
);

	logic [fpu_misc_pkg::COUNT_W-1:0] load_val;
	logic [fpu_misc_pkg::COUNT_W-1:0] count;
	logic                             active;

	// two of the cycles are spent on capture and start
	always_comb
	begin
		case (req.op)
			fpu_misc_pkg::OP_SGNJ:   load_val = SGNJ_CYCLES - 7'd2;
			fpu_misc_pkg::OP_CLASS:  load_val = CLASS_CYCLES - 7'd2;
			fpu_misc_pkg::OP_CMP:    load_val = CMP_CYCLES - 7'd2;
			default:                 load_val = MINMAX_CYCLES - 7'd2;
		endcase
	end

	assign done = active && (count == '0);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			active <= 1'b0;
			count  <= '0;
		end
		else if (start)
		begin
			active <= 1'b1;
			count  <= load_val;
		end
		else if (active)
		begin
			if (count == '0)
				active <= 1'b0;
			else
				count <= count - 7'd1;
		end
	end

endmodule

/* source/fpu_sign_inject.sv */
/*
 * sign injection on the captured operands
 */
module fpu_sign_inject
(
	fpu_req_if.unit                         req,
	output logic [fpu_misc_pkg::DATA_W-1:0] sgnj_result
);

	localparam int SB = fpu_misc_pkg::DATA_W - 1;

	logic a_sign;
	logic b_sign;

	assign a_sign = req.opa[SB];
	assign b_sign = req.opb[SB];

	// magnitude always comes from operand a
	always_comb
	begin
		case (req.fn)
			fpu_misc_pkg::FN_SGNJ:
				sgnj_result = {b_sign, req.opa[SB-1:0]};
			fpu_misc_pkg::FN_SGNJX:
				sgnj_result = {a_sign ^ b_sign, req.opa[SB-1:0]};
			fpu_misc_pkg::FN_SGNJN:
				sgnj_result = {~b_sign, req.opa[SB-1:0]};
			fpu_misc_pkg::FN_COPY:
				sgnj_result = req.opa;
			default:
				sgnj_result = fpu_misc_pkg::ILLEGAL_RESULT;
		endcase
	end

endmodule

/* source/fpu_classify.sv */
/*
 * ten-way fclass decode of operand a into a one-hot mask
 */
module fpu_classify
(
	fpu_req_if.unit                         req,
	output logic [fpu_misc_pkg::DATA_W-1:0] class_mask
);

	localparam int EW = fpu_misc_pkg::EXP_W;
	localparam int MW = fpu_misc_pkg::MAN_W;

	logic          sign;
	logic [EW-1:0] exponent;
	logic [MW-1:0] mantissa;
	logic          exp_max;
	logic          exp_zero;
	logic          man_zero;

	assign sign     = req.opa[EW+MW];
	assign exponent = req.opa[MW +: EW];
	assign mantissa = req.opa[MW-1:0];
	assign exp_max  = &exponent;
	assign exp_zero = (exponent == '0);
	assign man_zero = (mantissa == '0);

	always_comb
	begin
		class_mask = '0;
		if (exp_max && !man_zero)
		begin
			// top mantissa bit separates quiet from signalling
			if (mantissa[MW-1])
				class_mask[fpu_misc_pkg::CLS_QNAN] = 1'b1;
			else
				class_mask[fpu_misc_pkg::CLS_SNAN] = 1'b1;
		end
		else if (exp_max)
			class_mask[sign ? fpu_misc_pkg::CLS_NEG_INF : fpu_misc_pkg::CLS_POS_INF] = 1'b1;
		else if (exp_zero && man_zero)
			class_mask[sign ? fpu_misc_pkg::CLS_NEG_ZERO : fpu_misc_pkg::CLS_POS_ZERO] = 1'b1;
		else if (exp_zero)
			class_mask[sign ? fpu_misc_pkg::CLS_NEG_SUB : fpu_misc_pkg::CLS_POS_SUB] = 1'b1;
		else
			class_mask[sign ? fpu_misc_pkg::CLS_NEG_NORM : fpu_misc_pkg::CLS_POS_NORM] = 1'b1;
	end

endmodule

/* source/fpu_compare.sv */
/*
 * IEEE ordering of the two operands, feeding fle/flt/feq and
 * fmin/fmax with NaN handling and the invalid flags
 */
module fpu_compare
(
	fpu_req_if.unit                         req,
	output logic [fpu_misc_pkg::DATA_W-1:0] cmp_result,
	output logic [fpu_misc_pkg::DATA_W-1:0] minmax_result,
	output logic                            cmp_invalid,
	output logic                            minmax_invalid
);

	localparam int DW = fpu_misc_pkg::DATA_W;
	localparam int MW = fpu_misc_pkg::MAN_W;
	localparam int EW = fpu_misc_pkg::EXP_W;

	logic          a_sign, b_sign;
	logic [DW-2:0] a_mag, b_mag;
	logic          a_nan, b_nan, a_snan, b_snan;
	logic          any_nan, any_snan, both_zero;
	logic          raw_lt, ord_lt, ord_eq, mm_lt;

	assign a_sign = req.opa[DW-1];
	assign b_sign = req.opb[DW-1];
	assign a_mag  = req.opa[DW-2:0];
	assign b_mag  = req.opb[DW-2:0];

	////////////////////////////////////////////////
	// NaN detection
	////////////////////////////////////////////////
	assign a_nan    = (&req.opa[MW +: EW]) && (req.opa[MW-1:0] != '0);
	assign b_nan    = (&req.opb[MW +: EW]) && (req.opb[MW-1:0] != '0);
	assign a_snan   = a_nan && !req.opa[MW-1];
	assign b_snan   = b_nan && !req.opb[MW-1];
	assign any_nan  = a_nan || b_nan;
	assign any_snan = a_snan || b_snan;

	assign both_zero = (a_mag == '0) && (b_mag == '0);

	// same-sign order follows the magnitude, reversed when negative
	assign raw_lt = a_sign ? (a_mag > b_mag) : (a_mag < b_mag);

	// +0 and -0 are equal for the relations
	assign ord_lt = !any_nan && ((a_sign != b_sign) ? (a_sign && !both_zero) : raw_lt);
	assign ord_eq = !any_nan && ((req.opa == req.opb) || both_zero);

	// min/max puts -0 below +0
	assign mm_lt = (a_sign != b_sign) ? a_sign : raw_lt;

	always_comb
	begin
		cmp_invalid = 1'b0;
		case (req.fn)
			fpu_misc_pkg::FN_FLE:
			begin
				cmp_result  = {{(DW-1){1'b0}}, ord_lt || ord_eq};
				cmp_invalid = any_nan;
			end
			fpu_misc_pkg::FN_FLT:
			begin
				cmp_result  = {{(DW-1){1'b0}}, ord_lt};
				cmp_invalid = any_nan;
			end
			fpu_misc_pkg::FN_FEQ:
			begin
				cmp_result  = {{(DW-1){1'b0}}, ord_eq};
				cmp_invalid = any_snan;
			end
			default:
				cmp_result = fpu_misc_pkg::ILLEGAL_RESULT;
		endcase
	end

	always_comb
	begin
		minmax_invalid = 1'b0;
		if (req.fn != fpu_misc_pkg::FN_MIN && req.fn != fpu_misc_pkg::FN_MAX)
			minmax_result = fpu_misc_pkg::ILLEGAL_RESULT;
		else
		begin
			minmax_invalid = any_snan;
			if (a_nan && b_nan)
				minmax_result = fpu_misc_pkg::CANON_NAN;
			else if (a_nan)
				minmax_result = req.opb;
			else if (b_nan)
				minmax_result = req.opa;
			else if (mm_lt == (req.fn == fpu_misc_pkg::FN_MIN))
				minmax_result = req.opa;
			else
				minmax_result = req.opb;
		end
	end

endmodule

/* source/fpu_result_stage.sv */
/*
 * result selection by operation and the output holding register
 */
module fpu_result_stage
(
	input  logic                            clk,
	input  logic                            rst,
	fpu_req_if.unit                         req,
	input  logic [fpu_misc_pkg::DATA_W-1:0] sgnj_result,
	input  logic [fpu_misc_pkg::DATA_W-1:0] class_mask,
	input  logic [fpu_misc_pkg::DATA_W-1:0] cmp_result,
	input  logic [fpu_misc_pkg::DATA_W-1:0] minmax_result,
	input  logic                            cmp_invalid,
	input  logic                            minmax_invalid,
	input  logic                            capture,
	output logic [fpu_misc_pkg::DATA_W-1:0] result,
	output logic                            invalid
);

	logic [fpu_misc_pkg::DATA_W-1:0] sel_result;
	logic                            sel_invalid;

	// sign injection and classify never raise invalid
	always_comb
	begin
		sel_invalid = 1'b0;
		case (req.op)
			fpu_misc_pkg::OP_SGNJ:  sel_result = sgnj_result;
			fpu_misc_pkg::OP_CLASS: sel_result = class_mask;
			fpu_misc_pkg::OP_CMP:
			begin
				sel_result  = cmp_result;
				sel_invalid = cmp_invalid;
			end
			fpu_misc_pkg::OP_MINMAX:
			begin
				sel_result  = minmax_result;
				sel_invalid = minmax_invalid;
			end
			default: sel_result = fpu_misc_pkg::ILLEGAL_RESULT;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			result  <= '0;
			invalid <= 1'b0;
		end
		else if (capture)
		begin
			result  <= sel_result;
			invalid <= sel_invalid;
		end
	end

endmodule

/* source/fpu_misc_top.sv */
/*
 * misc double-precision FPU top: sequencer, latency timer,
 * sign injection, classify, compare and result stage
 */
module fpu_misc_top
#(
	parameter logic [fpu_misc_pkg::COUNT_W-1:0] SGNJ_CYCLES   = fpu_misc_pkg::DEF_SGNJ_CYCLES,
	parameter logic [fpu_misc_pkg::COUNT_W-1:0] CLASS_CYCLES  = fpu_misc_pkg::DEF_CLASS_CYCLES,
	parameter logic [fpu_misc_pkg::COUNT_W-1:0] CMP_CYCLES    = fpu_misc_pkg::DEF_CMP_CYCLES,
	parameter logic [fpu_misc_pkg::COUNT_W-1:0] MINMAX_CYCLES = fpu_misc_pkg::DEF_MINMAX_CYCLES
)
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            in_valid,
	output logic                            in_ready,
	input  fpu_misc_pkg::fpu_op_e           op,
	input  logic [fpu_misc_pkg::FN_W-1:0]   fn,
	input  logic [fpu_misc_pkg::DATA_W-1:0] opa,
	input  logic [fpu_misc_pkg::DATA_W-1:0] opb,
	output logic                            out_valid,
	input  logic                            out_ready,
	output logic [fpu_misc_pkg::DATA_W-1:0] result,
	output logic                            invalid
);

	fpu_req_if req ();

	logic                            start;
	logic                            done;
	logic                            capture;
	logic [fpu_misc_pkg::DATA_W-1:0] sgnj_result;
	logic [fpu_misc_pkg::DATA_W-1:0] class_mask;
	logic [fpu_misc_pkg::DATA_W-1:0] cmp_result;
	logic [fpu_misc_pkg::DATA_W-1:0] minmax_result;
	logic                            cmp_invalid;
	logic                            minmax_invalid;

	////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////
	fpu_op_sequencer u_seq
	(
		.clk, .rst, .in_valid, .op, .fn, .opa, .opb, .in_ready,
		.req(req.seq), .start, .done, .capture, .out_valid, .out_ready
	);

	fpu_latency_timer
	#(
		.SGNJ_CYCLES(SGNJ_CYCLES), .CLASS_CYCLES(CLASS_CYCLES),
		.CMP_CYCLES(CMP_CYCLES), .MINMAX_CYCLES(MINMAX_CYCLES)
	)
	u_timer (.clk, .rst, .req(req.unit), .start, .done);

	////////////////////////////////////////////////
	// data units and result
	////////////////////////////////////////////////
	fpu_sign_inject u_sgnj (.req(req.unit), .sgnj_result);

	fpu_classify u_class (.req(req.unit), .class_mask);

	fpu_compare u_cmp
	(
		.req(req.unit), .cmp_result, .minmax_result, .cmp_invalid, .minmax_invalid
	);

	fpu_result_stage u_res
	(
		.clk, .rst, .req(req.unit), .sgnj_result, .class_mask, .cmp_result,
		.minmax_result, .cmp_invalid, .minmax_invalid, .capture, .result, .invalid
	);

endmodule

/* verification/fpu_misc_asserts.sv */
/*
 * handshake and timing assertions, bound into the sequencer
 */
module fpu_misc_asserts
(
	input logic clk,
	input logic rst,
	input logic in_ready,
	input logic out_valid,
	input logic out_ready,
	input logic start
);

	// idle and presenting are separate states
	ready_valid_excl: assert property (@(posedge clk) disable iff (rst)
		!(in_ready && out_valid))
		else $error("in_ready and out_valid high together");

	// a stalled result stays presented
	hold_valid: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid)
		else $error("out_valid dropped under back-pressure");

	// start only in BUSY
	start_in_busy: assert property (@(posedge clk) disable iff (rst)
		start |-> !in_ready && !out_valid)
		else $error("start pulsed outside BUSY");

endmodule

bind fpu_op_sequencer fpu_misc_asserts asserts_inst
(
	.clk(clk), .rst(rst), .in_ready(in_ready), .out_valid(out_valid),
	.out_ready(out_ready), .start(start)
);

/* verification/fpu_misc_tb.sv */
/*
 * testbench for the misc FPU: clock and reset, stimulus, reference model,
 * result checker, latency and back-pressure checks, watchdog
 */
module fpu_misc_tb;

	localparam int DW          = fpu_misc_pkg::DATA_W;
	localparam int PERIOD      = 4;
	localparam int RST_CYCLES  = 8;
	localparam int SGNJ_PER_FN = 20;
	localparam int RAND_PAIRS  = 10;
	localparam int BP_OPS      = 20;
	localparam int MAX_STALL   = 15;

	function automatic int op_latency(input fpu_misc_pkg::fpu_op_e l_op);
		case (l_op)
			fpu_misc_pkg::OP_SGNJ:  return int'(fpu_misc_pkg::DEF_SGNJ_CYCLES);
			fpu_misc_pkg::OP_CLASS: return int'(fpu_misc_pkg::DEF_CLASS_CYCLES);
			fpu_misc_pkg::OP_CMP:   return int'(fpu_misc_pkg::DEF_CMP_CYCLES);
			default:                return int'(fpu_misc_pkg::DEF_MINMAX_CYCLES);
		endcase
	endfunction

	function automatic int largest_latency();
		int m;
		m = op_latency(fpu_misc_pkg::OP_SGNJ);
		if (op_latency(fpu_misc_pkg::OP_CLASS) > m)
			m = op_latency(fpu_misc_pkg::OP_CLASS);
		if (op_latency(fpu_misc_pkg::OP_CMP) > m)
			m = op_latency(fpu_misc_pkg::OP_CMP);
		if (op_latency(fpu_misc_pkg::OP_MINMAX) > m)
			m = op_latency(fpu_misc_pkg::OP_MINMAX);
		return m;
	endfunction

	// sgnj, classify, 3 compare and 2 min/max sweeps, back-pressure, illegal codes
	localparam int NUM_OPS  = 4 * SGNJ_PER_FN + 20 + 5 * (100 + RAND_PAIRS) + BP_OPS + 15;
	localparam int MAX_LAT  = largest_latency();
	localparam int WD_CYCLES = RST_CYCLES + NUM_OPS * (MAX_LAT + MAX_STALL + 4) + 100;

	logic                          clk;
	logic                          rst;
	logic                          in_valid;
	logic                          in_ready;
	fpu_misc_pkg::fpu_op_e         op;
	logic [fpu_misc_pkg::FN_W-1:0] fn;
	logic [DW-1:0]                 opa;
	logic [DW-1:0]                 opb;
	logic                          out_valid;
	logic                          out_ready;
	logic [DW-1:0]                 result;
	logic                          invalid;

	logic [63:0] rng_state     = 64'd65705;
	logic [DW:0] expect_q[$];
	string       name_q[$];
	int          issued_count  = 0;
	int          checked_count = 0;
	logic        fail_reported = 1'b0;
	logic        run_passed    = 1'b0;

	// one directed operand per class, in class bit order
	logic [DW-1:0] specials [10] = '{
		64'hFFF0_0000_0000_0000, 64'hBFF0_0000_0000_0000, 64'h8000_0000_0000_0001,
		64'h8000_0000_0000_0000, 64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001,
		64'h3FF0_0000_0000_0000, 64'h7FF0_0000_0000_0000, 64'h7FF0_0000_0000_0001,
		64'h7FF8_0000_0000_0000
	};

	fpu_misc_top
	#(
		.SGNJ_CYCLES(fpu_misc_pkg::DEF_SGNJ_CYCLES), .CLASS_CYCLES(fpu_misc_pkg::DEF_CLASS_CYCLES),
		.CMP_CYCLES(fpu_misc_pkg::DEF_CMP_CYCLES), .MINMAX_CYCLES(fpu_misc_pkg::DEF_MINMAX_CYCLES)
	)
	fpu_misc_top_inst
	(
		.clk, .rst, .in_valid, .in_ready, .op, .fn, .opa, .opb,
		.out_valid, .out_ready, .result, .invalid
	);

	always #(PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////
	// random source and reference model
	////////////////////////////////////////////////
	function automatic logic [63:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 7);
		rng_state = rng_state ^ (rng_state << 17);
		return rng_state;
	endfunction

	function automatic logic [DW-1:0] pick_operand();
		logic [63:0] r;
		r = next_rand();
		if (r[2:0] < 3'd3)
			return specials[int'(r[11:8]) % 10];
		return next_rand();
	endfunction

	function automatic int small_stall();
		return int'(next_rand() % 64'd3);
	endfunction

	function automatic logic is_nan(input logic [DW-1:0] x);
		return (x[62:52] == 11'h7FF) && (x[51:0] != 52'd0);
	endfunction

	// maps IEEE order onto unsigned order, -0 just below +0
	function automatic logic [DW-1:0] order_key(input logic [DW-1:0] x);
		return x[63] ? ~x : {1'b1, x[62:0]};
	endfunction

	// returns {invalid, result}
	function automatic logic [DW:0] fpu_ref(input fpu_misc_pkg::fpu_op_e f_op,
		input logic [2:0] f_fn, input logic [DW-1:0] a, input logic [DW-1:0] b);
		logic [DW-1:0] res;
		logic          inv;
		logic          nan_a, nan_b, snan_any, zeros, lt, eq;
		nan_a    = is_nan(a);
		nan_b    = is_nan(b);
		snan_any = (nan_a && !a[51]) || (nan_b && !b[51]);
		zeros    = (a[62:0] == 63'd0) && (b[62:0] == 63'd0);
		eq       = !nan_a && !nan_b && (zeros || a == b);
		lt       = !nan_a && !nan_b && !zeros && (order_key(a) < order_key(b));
		inv      = 1'b0;
		res      = fpu_misc_pkg::ILLEGAL_RESULT;
		case (f_op)
			fpu_misc_pkg::OP_SGNJ:
				case (f_fn)
					fpu_misc_pkg::FN_SGNJ:  res = {b[63], a[62:0]};
					fpu_misc_pkg::FN_SGNJX: res = {a[63] ^ b[63], a[62:0]};
					fpu_misc_pkg::FN_SGNJN: res = {~b[63], a[62:0]};
					fpu_misc_pkg::FN_COPY:  res = a;
					default: ;
				endcase
			fpu_misc_pkg::OP_CLASS:
			begin
				res = '0;
				if (nan_a)
					res[a[51] ? fpu_misc_pkg::CLS_QNAN : fpu_misc_pkg::CLS_SNAN] = 1'b1;
				else if (a[62:52] == 11'h7FF)
					res[a[63] ? fpu_misc_pkg::CLS_NEG_INF : fpu_misc_pkg::CLS_POS_INF] = 1'b1;
				else if (a[62:0] == 63'd0)
					res[a[63] ? fpu_misc_pkg::CLS_NEG_ZERO : fpu_misc_pkg::CLS_POS_ZERO] = 1'b1;
				else if (a[62:52] == 11'd0)
					res[a[63] ? fpu_misc_pkg::CLS_NEG_SUB : fpu_misc_pkg::CLS_POS_SUB] = 1'b1;
				else
					res[a[63] ? fpu_misc_pkg::CLS_NEG_NORM : fpu_misc_pkg::CLS_POS_NORM] = 1'b1;
			end
			fpu_misc_pkg::OP_CMP:
				case (f_fn)
					fpu_misc_pkg::FN_FLE:
					begin
						res = {63'd0, lt || eq};
						inv = nan_a || nan_b;
					end
					fpu_misc_pkg::FN_FLT:
					begin
						res = {63'd0, lt};
						inv = nan_a || nan_b;
					end
					fpu_misc_pkg::FN_FEQ:
					begin
						res = {63'd0, eq};
						inv = snan_any;
					end
					default: ;
				endcase
			default:
				if (f_fn == fpu_misc_pkg::FN_MIN || f_fn == fpu_misc_pkg::FN_MAX)
				begin
					inv = snan_any;
					if (nan_a && nan_b)
						res = fpu_misc_pkg::CANON_NAN;
					else if (nan_a)
						res = b;
					else if (nan_b)
						res = a;
					else if (f_fn == fpu_misc_pkg::FN_MIN)
						res = (order_key(a) < order_key(b)) ? a : b;
					else
						res = (order_key(a) > order_key(b)) ? a : b;
				end
		endcase
		return {inv, res};
	endfunction

	////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////
	task automatic abort_run(input string why);
		fail_reported = 1'b1;
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_result(input string name, input logic [DW-1:0] expected,
		input logic [DW-1:0] actual);
		if (actual !== expected)
			abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_invalid(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("CHECK FAILED %s invalid: expected %b, actual %b",
				name, expected, actual));
	endtask

	// result is stable here, ahead of the consuming edge
	always @(negedge clk)
	begin
		if (!rst && out_valid && out_ready)
		begin
			if (expect_q.size() == 0)
				abort_run("a result was handed out with no request pending");
			check_result(name_q[0], expect_q[0][DW-1:0], result);
			check_invalid(name_q[0], expect_q[0][DW], invalid);
			expect_q.delete(0);
			name_q.delete(0);
			checked_count++;
		end
	end

	////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////
	task automatic run_op(input fpu_misc_pkg::fpu_op_e t_op, input logic [2:0] t_fn,
		input logic [DW-1:0] a, input logic [DW-1:0] b, input int stall, input string name);
		logic [DW-1:0] held_result;
		logic          held_invalid;
		int            lat;
		int            n;
		lat = op_latency(t_op);
		while (!in_ready)
		begin
			@(posedge clk);
			#1;
		end
		expect_q.push_back(fpu_ref(t_op, t_fn, a, b));
		name_q.push_back(name);
		issued_count++;
		in_valid = 1'b1;
		op       = t_op;
		fn       = t_fn;
		opa      = a;
		opb      = b;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		// latency counted in edges after the acceptance edge
		for (n = 1; n <= lat; n++)
		begin
			@(posedge clk);
			#1;
			if (in_ready)
				abort_run($sformatf("%s: in_ready high %0d edges after acceptance", name, n));
			if (out_valid && n < lat)
				abort_run($sformatf("%s: out_valid came %0d edges after acceptance, expected %0d",
					name, n, lat));
			if (!out_valid && n == lat)
				abort_run($sformatf("%s: out_valid missing %0d edges after acceptance", name, lat));
		end
		held_result  = result;
		held_invalid = invalid;
		// a competing request waits through the stall
		in_valid = (stall > 0);
		for (n = 0; n < stall; n++)
		begin
			@(posedge clk);
			#1;
			if (!out_valid || in_ready)
				abort_run($sformatf("%s: result dropped or new request taken while stalled", name));
			check_result({name, " held"}, held_result, result);
			check_invalid({name, " held"}, held_invalid, invalid);
		end
		in_valid  = 1'b0;
		out_ready = 1'b1;
		@(posedge clk);
		#1;
		out_ready = 1'b0;
		if (out_valid)
			abort_run($sformatf("%s: out_valid still high after the consuming edge", name));
	endtask

	task automatic sweep_pairs(input fpu_misc_pkg::fpu_op_e t_op, input int fn_count,
		input string label);
		logic [DW-1:0] a_val;
		logic [DW-1:0] b_val;
		int            f;
		int            k;
		for (f = 0; f < fn_count; f++)
		begin
			for (k = 0; k < 100 + RAND_PAIRS; k++)
			begin
				if (k < 100)
				begin
					a_val = specials[k / 10];
					b_val = specials[k % 10];
				end
				else
				begin
					a_val = pick_operand();
					b_val = k[0] ? a_val : pick_operand();
				end
				run_op(t_op, 3'(f), a_val, b_val, small_stall(),
					$sformatf("%s fn%0d #%0d", label, f, k));
			end
		end
	endtask

	initial
	begin
		int                    f;
		int                    i;
		logic [63:0]           r;
		fpu_misc_pkg::fpu_op_e bp_op;
		clk       = 1'b0;
		rst       = 1'b1;
		in_valid  = 1'b0;
		op        = fpu_misc_pkg::OP_SGNJ;
		fn        = '0;
		opa       = '0;
		opb       = '0;
		out_ready = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		if (!in_ready || out_valid)
			abort_run("after reset in_ready should be high and out_valid low");

		for (f = 0; f < 4; f++)
			for (i = 0; i < SGNJ_PER_FN; i++)
				run_op(fpu_misc_pkg::OP_SGNJ, 3'(f), (i < 10) ? specials[i] : pick_operand(),
					pick_operand(), small_stall(), $sformatf("sgnj fn%0d #%0d", f, i));

		for (i = 0; i < 20; i++)
			run_op(fpu_misc_pkg::OP_CLASS, 3'd0, (i < 10) ? specials[i] : pick_operand(),
				64'd0, small_stall(), $sformatf("class #%0d", i));

		sweep_pairs(fpu_misc_pkg::OP_CMP, 3, "cmp");
		sweep_pairs(fpu_misc_pkg::OP_MINMAX, 2, "minmax");

		// long stalls on random operations
		for (i = 0; i < BP_OPS; i++)
		begin
			r     = next_rand();
			bp_op = fpu_misc_pkg::fpu_op_e'(r[1:0]);
			run_op(bp_op, {2'b00, r[4]}, pick_operand(), pick_operand(), int'(r[11:8]),
				$sformatf("backpressure #%0d", i));
		end

		for (f = 4; f < 8; f++)
			run_op(fpu_misc_pkg::OP_SGNJ, 3'(f), pick_operand(), pick_operand(), 0,
				$sformatf("illegal sgnj fn%0d", f));
		for (f = 3; f < 8; f++)
			run_op(fpu_misc_pkg::OP_CMP, 3'(f), pick_operand(), pick_operand(), 0,
				$sformatf("illegal cmp fn%0d", f));
		for (f = 2; f < 8; f++)
			run_op(fpu_misc_pkg::OP_MINMAX, 3'(f), pick_operand(), pick_operand(), 0,
				$sformatf("illegal minmax fn%0d", f));

		if (checked_count == issued_count && expect_q.size() == 0)
		begin
			run_passed = 1'b1;
			$display(">>> PASS");
			$finish;
		end
		else
			abort_run($sformatf("%0d requests issued but %0d results checked",
				issued_count, checked_count));
	end

	initial
	begin
		#(WD_CYCLES * PERIOD);
		abort_run("watchdog expired before all operations completed");
	end

	final
	begin
		if (!run_passed && !fail_reported)
			$display(">>> FAIL");
	end

endmodule

/* src.f */
source/fpu_misc_pkg.sv
source/fpu_req_if.sv
source/fpu_op_sequencer.sv
source/fpu_latency_timer.sv
source/fpu_sign_inject.sv
source/fpu_classify.sv
source/fpu_compare.sv
source/fpu_result_stage.sv
source/fpu_misc_top.sv
verification/fpu_misc_asserts.sv
verification/fpu_misc_tb.sv

/* Makefile */
# Verilator build and run for the misc FPU testbench

VERILATOR ?= verilator
TOP       ?= fpu_misc_tb
FILE_LIST ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= >>> PASS

SOURCES := $(wildcard source/*.sv verification/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
